//--- logic/hci_pkg.sv
// wide and narrow HCI port widths plus the wide data word type, referenced as hci_pkg::name
`default_nettype none

package hci_pkg;

  // channel count equals the bank count of the TCDM
  localparam int unsigned NB_CHAN = 2;

  localparam int unsigned WIDE_DW = 64;                // wide data width
  localparam int unsigned LANE_DW = WIDE_DW / NB_CHAN; // one bank word
  localparam int unsigned LANE_BW = LANE_DW / 8;       // byte enables per lane
  localparam int unsigned WIDE_BW = WIDE_DW / 8;       // byte enables on the wide port

  localparam int unsigned AW = 32; // byte address
  localparam int unsigned UW = 2;  // user tag, returned with the response

  // one wide data word
  // the split slices it into lanes, the accelerator side sees it whole
  typedef union packed {
    logic [WIDE_DW-1:0]              word; // as carried on data_i and r_data_o
    logic [NB_CHAN-1:0][LANE_DW-1:0] lane; // lane i goes to bank i
  } hci_wide_word_u;

endpackage

`default_nettype wire

//--- logic/tcdm_pkg.sv
// TCDM bank geometry and address field positions, referenced as tcdm_pkg::name
`default_nettype none

package tcdm_pkg;

  localparam int unsigned BANK_WORDS = 256; // words held by each bank

  // word interleaving, so the bank index sits just above the byte offset
  localparam int unsigned BANK_IDX_W = $clog2(hci_pkg::NB_CHAN);

  localparam int unsigned ROW_W = $clog2(BANK_WORDS); // row select inside a bank

  // first address bit of the row field
  localparam int unsigned ROW_LSB = $clog2(hci_pkg::LANE_BW) + BANK_IDX_W;

endpackage

`default_nettype wire

//--- logic/hci_chan_fifo.sv
// per-lane request and response queues between the wide split and one TCDM bank
`timescale 1ns/1ns
`default_nettype none

module hci_chan_fifo #(
  parameter int unsigned DEPTH = 4 // entries in each queue
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  // target side, toward the split
  input  logic                        req_i,
  output logic                        gnt_o,
  input  logic                        wen_i,   // 1 means read
  input  logic [hci_pkg::AW-1:0]      add_i,
  input  logic [hci_pkg::LANE_BW-1:0] be_i,
  input  logic [hci_pkg::LANE_DW-1:0] data_i,
  input  logic [hci_pkg::UW-1:0]      user_i,
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output logic [hci_pkg::LANE_DW-1:0] r_data_o,
  output logic [hci_pkg::UW-1:0]      r_user_o,
  // bank side
  output logic                        bank_req_o,
  input  logic                        bank_gnt_i,
  output logic                        bank_wen_o,
  output logic [hci_pkg::AW-1:0]      bank_add_o,
  output logic [hci_pkg::LANE_BW-1:0] bank_be_o,
  output logic [hci_pkg::LANE_DW-1:0] bank_data_o,
  input  logic                        bank_r_valid_i,
  input  logic [hci_pkg::LANE_DW-1:0] bank_r_data_i
);

  // request queue storage
  logic                        q_wen  [DEPTH];
  logic [hci_pkg::AW-1:0]      q_add  [DEPTH];
  logic [hci_pkg::LANE_BW-1:0] q_be   [DEPTH];
  logic [hci_pkg::LANE_DW-1:0] q_data [DEPTH];
  logic [$clog2(DEPTH)-1:0]    q_wr_q;
  logic [$clog2(DEPTH)-1:0]    q_rd_q;
  logic [$clog2(DEPTH+1)-1:0]  q_cnt_q;

  // response queue storage
  logic [hci_pkg::LANE_DW-1:0] rsp_mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]    rsp_wr_q;
  logic [$clog2(DEPTH)-1:0]    rsp_rd_q;
  logic [$clog2(DEPTH+1)-1:0]  rsp_cnt_q;
  logic [$clog2(DEPTH+1)-1:0]  out_cnt_q; // granted by the bank, answer not back yet

  // tags cover queued, in-flight and answered requests, hence twice the depth
  logic [hci_pkg::UW-1:0]     tag_mem [2*DEPTH];
  logic [$clog2(2*DEPTH)-1:0] tag_wr_q;
  logic [$clog2(2*DEPTH)-1:0] tag_rd_q;

  logic push;  // request enters the queue
  logic issue; // request handed to the bank
  logic pop;   // response leaves toward the split

  assign gnt_o = (q_cnt_q != DEPTH); // room in the request queue
  assign push  = req_i & gnt_o;

  // only ask the bank when its answer is sure to find a free response slot
  assign bank_req_o  = (q_cnt_q != '0) && ((out_cnt_q + rsp_cnt_q) < DEPTH);
  assign issue       = bank_req_o & bank_gnt_i;
  assign bank_wen_o  = q_wen[q_rd_q];
  assign bank_add_o  = q_add[q_rd_q];
  assign bank_be_o   = q_be[q_rd_q];
  assign bank_data_o = q_data[q_rd_q];

  assign r_valid_o = (rsp_cnt_q != '0);
  assign pop       = r_valid_o & r_ready_i;
  assign r_data_o  = rsp_mem[rsp_rd_q];
  assign r_user_o  = tag_mem[tag_rd_q]; // tag order follows response order

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      q_wr_q    <= '0;
      q_rd_q    <= '0;
      q_cnt_q   <= '0;
      rsp_wr_q  <= '0;
      rsp_rd_q  <= '0;
      rsp_cnt_q <= '0;
      out_cnt_q <= '0;
      tag_wr_q  <= '0;
      tag_rd_q  <= '0;
    end else if (clear_i) begin
      q_wr_q    <= '0;
      q_rd_q    <= '0;
      q_cnt_q   <= '0;
      rsp_wr_q  <= '0;
      rsp_rd_q  <= '0;
      rsp_cnt_q <= '0;
      out_cnt_q <= '0;
      tag_wr_q  <= '0;
      tag_rd_q  <= '0;
    end else begin
      if (push) begin
        q_wr_q   <= (q_wr_q == DEPTH-1) ? '0 : q_wr_q + 1'b1;
        tag_wr_q <= (tag_wr_q == 2*DEPTH-1) ? '0 : tag_wr_q + 1'b1;
      end
      if (issue) begin
        q_rd_q <= (q_rd_q == DEPTH-1) ? '0 : q_rd_q + 1'b1;
      end
      if (bank_r_valid_i) begin
        rsp_wr_q <= (rsp_wr_q == DEPTH-1) ? '0 : rsp_wr_q + 1'b1;
      end
      if (pop) begin
        rsp_rd_q <= (rsp_rd_q == DEPTH-1) ? '0 : rsp_rd_q + 1'b1;
        tag_rd_q <= (tag_rd_q == 2*DEPTH-1) ? '0 : tag_rd_q + 1'b1;
      end
      if (push != issue) begin
        q_cnt_q <= push ? q_cnt_q + 1'b1 : q_cnt_q - 1'b1;
      end
      if (bank_r_valid_i != pop) begin
        rsp_cnt_q <= bank_r_valid_i ? rsp_cnt_q + 1'b1 : rsp_cnt_q - 1'b1;
      end
      if (issue != bank_r_valid_i) begin
        out_cnt_q <= issue ? out_cnt_q + 1'b1 : out_cnt_q - 1'b1;
      end
    end
  end

  // queue payload
  always_ff @(posedge clk_i) begin
    if (push) begin
      q_wen[q_wr_q]     <= wen_i;
      q_add[q_wr_q]     <= add_i;
      q_be[q_wr_q]      <= be_i;
      q_data[q_wr_q]    <= data_i;
      tag_mem[tag_wr_q] <= user_i; // bank never sees the tag
    end
    if (bank_r_valid_i) begin
      rsp_mem[rsp_wr_q] <= bank_r_data_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/tcdm_bank.sv
// one word-wide TCDM SRAM bank with byte enables, busy refusal and one-cycle response
`timescale 1ns/1ns
`default_nettype none

module tcdm_bank (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        wen_i,  // 1 means read
  input  logic                        busy_i, // another initiator holds the bank
  input  logic [hci_pkg::AW-1:0]      add_i,
  input  logic [hci_pkg::LANE_BW-1:0] be_i,
  input  logic [hci_pkg::LANE_DW-1:0] data_i,
  output logic                        gnt_o,
  output logic                        r_valid_o,
  output logic [hci_pkg::LANE_DW-1:0] r_data_o
);

  logic [hci_pkg::LANE_DW-1:0] mem_q [tcdm_pkg::BANK_WORDS];
  logic [tcdm_pkg::ROW_W-1:0]  row;

  // byte offset and bank index bits are dropped
  assign row = add_i[tcdm_pkg::ROW_LSB +: tcdm_pkg::ROW_W];

  assign gnt_o = req_i & ~busy_i;

  // every grant gets an answer, reads and writes alike
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_o <= 1'b0;
    end else begin
      r_valid_o <= gnt_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      r_data_o <= mem_q[row]; // old word on a write
      if (!wen_i) begin
        for (int b = 0; b < hci_pkg::LANE_BW; b++) begin
          if (be_i[b]) begin
            mem_q[row][8*b +: 8] <= data_i[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/hci_wide_split.sv
// splits each wide HCI request into per-bank lanes and joins the lane responses back
`timescale 1ns/1ns
`default_nettype none

module hci_wide_split (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              clear_i,
  // wide target side
  input  logic                                              req_i,
  input  logic                                              wen_i, // 1 means read
  input  logic [hci_pkg::AW-1:0]                            add_i,
  input  logic [hci_pkg::WIDE_BW-1:0]                       be_i,
  input  logic [hci_pkg::WIDE_DW-1:0]                       data_i,
  input  logic [hci_pkg::UW-1:0]                            user_i,
  input  logic                                              r_ready_i,
  output logic                                              gnt_o,
  output logic                                              r_valid_o,
  output logic [hci_pkg::WIDE_DW-1:0]                       r_data_o,
  output logic [hci_pkg::UW-1:0]                            r_user_o,
  // lane initiator side
  output logic [hci_pkg::NB_CHAN-1:0]                       lane_req_o,
  output logic [hci_pkg::NB_CHAN-1:0]                       lane_wen_o,
  output logic [hci_pkg::NB_CHAN-1:0][hci_pkg::AW-1:0]      lane_add_o,
  output logic [hci_pkg::NB_CHAN-1:0][hci_pkg::LANE_BW-1:0] lane_be_o,
  output logic [hci_pkg::NB_CHAN-1:0][hci_pkg::LANE_DW-1:0] lane_data_o,
  output logic [hci_pkg::NB_CHAN-1:0][hci_pkg::UW-1:0]      lane_user_o,
  output logic [hci_pkg::NB_CHAN-1:0]                       lane_r_ready_o,
  input  logic [hci_pkg::NB_CHAN-1:0]                       lane_gnt_i,
  input  logic [hci_pkg::NB_CHAN-1:0]                       lane_r_valid_i,
  input  logic [hci_pkg::NB_CHAN-1:0][hci_pkg::LANE_DW-1:0] lane_r_data_i,
  input  logic [hci_pkg::NB_CHAN-1:0][hci_pkg::UW-1:0]      lane_r_user_i
);

  hci_pkg::hci_wide_word_u wdata; // write data, sliced per lane
  hci_pkg::hci_wide_word_u rdata; // read data, joined from lanes

  logic                        gnt_state_q; // 0 is GNT, 1 is NO-GNT
  logic                        gnt_state_d;
  logic [hci_pkg::NB_CHAN-1:0] gnt_mask_q;  // lanes already taken by their FIFO
  logic [hci_pkg::NB_CHAN-1:0] gnt_mask_d;
  logic [hci_pkg::NB_CHAN-1:0] lane_take;   // lanes enqueuing this cycle

  logic                        rv_state_q;  // 0 is RVALID, 1 is NO-RVALID
  logic                        rv_state_d;
  logic [hci_pkg::NB_CHAN-1:0] rv_mask_q;   // lanes whose response is waiting
  logic [hci_pkg::NB_CHAN-1:0] rv_mask_d;
  logic [hci_pkg::NB_CHAN-1:0] lane_here;   // response present, now or earlier
  logic                        rsp_take;    // wide response consumed

  assign wdata.word = data_i;

  // lane fan-out
  for (genvar i = 0; i < hci_pkg::NB_CHAN; i++) begin : g_lane
    assign lane_add_o[i]  = add_i + hci_pkg::AW'(i * hci_pkg::LANE_BW); // next word, next bank
    assign lane_be_o[i]   = be_i[i*hci_pkg::LANE_BW +: hci_pkg::LANE_BW];
    assign lane_wen_o[i]  = wen_i;
    assign lane_user_o[i] = user_i;
  end
  assign lane_data_o = wdata.lane;

  // granted lanes stay quiet until their siblings catch up
  assign lane_req_o = {hci_pkg::NB_CHAN{req_i}} & ~gnt_mask_q;
  assign lane_take  = lane_req_o & lane_gnt_i;
  assign gnt_o      = &(lane_gnt_i | gnt_mask_q); // mask is empty in GNT

  always_comb begin
    gnt_state_d = gnt_state_q;
    gnt_mask_d  = gnt_mask_q;
    if (!gnt_state_q) begin
      if (req_i && !gnt_o) begin // some lanes refused
        gnt_state_d = 1'b1;
        gnt_mask_d  = lane_take;
      end
    end else begin
      if (gnt_o) begin // last lanes go in now
        gnt_state_d = 1'b0;
        gnt_mask_d  = '0;
      end else begin
        gnt_mask_d = gnt_mask_q | lane_take;
      end
    end
  end

  // response join
  assign lane_here      = lane_r_valid_i | rv_mask_q;
  assign r_valid_o      = &lane_here;
  assign rsp_take       = r_valid_o & r_ready_i;
  assign lane_r_ready_o = {hci_pkg::NB_CHAN{rsp_take}}; // early lanes hold their head entry

  always_comb begin
    rv_state_d = rv_state_q;
    rv_mask_d  = rv_mask_q;
    if (!rv_state_q) begin
      if ((|lane_r_valid_i) && !r_valid_o) begin // partial arrival
        rv_state_d = 1'b1;
        rv_mask_d  = lane_r_valid_i;
      end
    end else begin
      if (rsp_take) begin
        rv_state_d = 1'b0;
        rv_mask_d  = '0;
      end else begin
        rv_mask_d = rv_mask_q | lane_r_valid_i;
      end
    end
  end

  // both masking FSMs
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_state_q <= 1'b0;
      gnt_mask_q  <= '0;
      rv_state_q  <= 1'b0;
      rv_mask_q   <= '0;
    end else if (clear_i) begin
      gnt_state_q <= 1'b0;
      gnt_mask_q  <= '0;
      rv_state_q  <= 1'b0;
      rv_mask_q   <= '0;
    end else begin
      gnt_state_q <= gnt_state_d;
      gnt_mask_q  <= gnt_mask_d;
      rv_state_q  <= rv_state_d;
      rv_mask_q   <= rv_mask_d;
    end
  end

  assign rdata.lane = lane_r_data_i;
  assign r_data_o   = rdata.word;
  assign r_user_o   = lane_r_user_i[0]; // every lane carries the same tag

endmodule

`default_nettype wire

//--- logic/hci_split_tcdm_top.sv
// wide accelerator port on a banked TCDM through the split, lane FIFOs and banks
`timescale 1ns/1ns
`default_nettype none

module hci_split_tcdm_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        req_i,
  input  logic                        wen_i,   // 1 means read
  input  logic [hci_pkg::AW-1:0]      add_i,
  input  logic [hci_pkg::WIDE_BW-1:0] be_i,
  input  logic [hci_pkg::WIDE_DW-1:0] data_i,
  input  logic [hci_pkg::UW-1:0]      user_i,
  input  logic                        r_ready_i,
  input  logic [hci_pkg::NB_CHAN-1:0] busy_i,  // one bit per bank
  output logic                        gnt_o,
  output logic                        r_valid_o,
  output logic [hci_pkg::WIDE_DW-1:0] r_data_o,
  output logic [hci_pkg::UW-1:0]      r_user_o
);

  // split to FIFO lanes
  logic [hci_pkg::NB_CHAN-1:0]                       lane_req;
  logic [hci_pkg::NB_CHAN-1:0]                       lane_gnt;
  logic [hci_pkg::NB_CHAN-1:0]                       lane_wen;
  logic [hci_pkg::NB_CHAN-1:0][hci_pkg::AW-1:0]      lane_add;
  logic [hci_pkg::NB_CHAN-1:0][hci_pkg::LANE_BW-1:0] lane_be;
  logic [hci_pkg::NB_CHAN-1:0][hci_pkg::LANE_DW-1:0] lane_data;
  logic [hci_pkg::NB_CHAN-1:0][hci_pkg::UW-1:0]      lane_user;
  logic [hci_pkg::NB_CHAN-1:0]                       lane_r_ready;
  logic [hci_pkg::NB_CHAN-1:0]                       lane_r_valid;
  logic [hci_pkg::NB_CHAN-1:0][hci_pkg::LANE_DW-1:0] lane_r_data;
  logic [hci_pkg::NB_CHAN-1:0][hci_pkg::UW-1:0]      lane_r_user;

  // FIFO to bank
  logic [hci_pkg::NB_CHAN-1:0]                       bank_req;
  logic [hci_pkg::NB_CHAN-1:0]                       bank_gnt;
  logic [hci_pkg::NB_CHAN-1:0]                       bank_wen;
  logic [hci_pkg::NB_CHAN-1:0][hci_pkg::AW-1:0]      bank_add;
  logic [hci_pkg::NB_CHAN-1:0][hci_pkg::LANE_BW-1:0] bank_be;
  logic [hci_pkg::NB_CHAN-1:0][hci_pkg::LANE_DW-1:0] bank_data;
  logic [hci_pkg::NB_CHAN-1:0]                       bank_r_valid;
  logic [hci_pkg::NB_CHAN-1:0][hci_pkg::LANE_DW-1:0] bank_r_data;

  hci_wide_split u_split (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .clear_i        ( clear_i      ),
    .req_i          ( req_i        ),
    .wen_i          ( wen_i        ),
    .add_i          ( add_i        ),
    .be_i           ( be_i         ),
    .data_i         ( data_i       ),
    .user_i         ( user_i       ),
    .r_ready_i      ( r_ready_i    ),
    .gnt_o          ( gnt_o        ),
    .r_valid_o      ( r_valid_o    ),
    .r_data_o       ( r_data_o     ),
    .r_user_o       ( r_user_o     ),
    .lane_req_o     ( lane_req     ),
    .lane_wen_o     ( lane_wen     ),
    .lane_add_o     ( lane_add     ),
    .lane_be_o      ( lane_be      ),
    .lane_data_o    ( lane_data    ),
    .lane_user_o    ( lane_user    ),
    .lane_r_ready_o ( lane_r_ready ),
    .lane_gnt_i     ( lane_gnt     ),
    .lane_r_valid_i ( lane_r_valid ),
    .lane_r_data_i  ( lane_r_data  ),
    .lane_r_user_i  ( lane_r_user  )
  );

  // lane i talks to bank i, no crossbar
  for (genvar i = 0; i < hci_pkg::NB_CHAN; i++) begin : g_chan
    hci_chan_fifo u_fifo (
      .clk_i          ( clk_i           ),
      .rst_ni         ( rst_ni          ),
      .clear_i        ( clear_i         ),
      .req_i          ( lane_req[i]     ),
      .gnt_o          ( lane_gnt[i]     ),
      .wen_i          ( lane_wen[i]     ),
      .add_i          ( lane_add[i]     ),
      .be_i           ( lane_be[i]      ),
      .data_i         ( lane_data[i]    ),
      .user_i         ( lane_user[i]    ),
      .r_valid_o      ( lane_r_valid[i] ),
      .r_ready_i      ( lane_r_ready[i] ),
      .r_data_o       ( lane_r_data[i]  ),
      .r_user_o       ( lane_r_user[i]  ),
      .bank_req_o     ( bank_req[i]     ),
      .bank_gnt_i     ( bank_gnt[i]     ),
      .bank_wen_o     ( bank_wen[i]     ),
      .bank_add_o     ( bank_add[i]     ),
      .bank_be_o      ( bank_be[i]      ),
      .bank_data_o    ( bank_data[i]    ),
      .bank_r_valid_i ( bank_r_valid[i] ),
      .bank_r_data_i  ( bank_r_data[i]  )
    );

    tcdm_bank u_bank (
      .clk_i     ( clk_i           ),
      .rst_ni    ( rst_ni          ),
      .req_i     ( bank_req[i]     ),
      .wen_i     ( bank_wen[i]     ),
      .busy_i    ( busy_i[i]       ),
      .add_i     ( bank_add[i]     ),
      .be_i      ( bank_be[i]      ),
      .data_i    ( bank_data[i]    ),
      .gnt_o     ( bank_gnt[i]     ),
      .r_valid_o ( bank_r_valid[i] ),
      .r_data_o  ( bank_r_data[i]  )
    );
  end

endmodule

`default_nettype wire

//--- tests/tb_hci_split_model.svh
// byte-level memory model, expected-response queue and compare tasks, included inside the testbench
`ifndef TB_HCI_SPLIT_MODEL_SVH
`define TB_HCI_SPLIT_MODEL_SVH

logic [7:0]              mem_b [256]; // byte image of the 32-word test region
logic                    exp_rd   [$]; // 1 for a read, write responses carry no data
hci_pkg::hci_wide_word_u exp_data [$];
logic [hci_pkg::UW-1:0]  exp_user [$];
int unsigned             err_cnt = 0;
int unsigned             acc_cnt = 0; // accepted wide requests
int unsigned             rsp_cnt = 0; // consumed wide responses

// lane by lane, so a swapped or stale lane shows up by itself
task automatic check_data(input hci_pkg::hci_wide_word_u exp_w,
                          input hci_pkg::hci_wide_word_u act_w);
  for (int i = 0; i < hci_pkg::NB_CHAN; i++) begin
    if (act_w.lane[i] !== exp_w.lane[i]) begin
      $display("ERR r_data_o lane %0d exp 0x%h got 0x%h", i, exp_w.lane[i], act_w.lane[i]);
      err_cnt++;
    end
  end
endtask

task automatic check_user(input logic [hci_pkg::UW-1:0] exp_u,
                          input logic [hci_pkg::UW-1:0] act_u);
  if (act_u !== exp_u) begin
    $display("ERR r_user_o exp 0x%h got 0x%h", exp_u, act_u);
    err_cnt++;
  end
endtask

task automatic check_count(input string name, input int unsigned exp_n, input int unsigned act_n);
  if (act_n != exp_n) begin
    $display("ERR %s exp 0x%0h got 0x%0h", name, exp_n, act_n);
    err_cnt++;
  end
endtask

// called once per accepted request, in acceptance order
task automatic model_accept(input logic rd, input int unsigned widx,
                            input logic [hci_pkg::WIDE_BW-1:0] be,
                            input logic [hci_pkg::WIDE_DW-1:0] data,
                            input logic [hci_pkg::UW-1:0] user);
  hci_pkg::hci_wide_word_u w;
  w.word = data;
  for (int b = 0; b < hci_pkg::WIDE_BW; b++) begin
    if (rd) begin
      w.word[8*b +: 8] = mem_b[widx*hci_pkg::WIDE_BW + b]; // byte b sits at add + b
    end else if (be[b]) begin
      mem_b[widx*hci_pkg::WIDE_BW + b] = data[8*b +: 8];
    end
  end
  exp_rd.push_back(rd);
  exp_data.push_back(w);
  exp_user.push_back(user);
  acc_cnt++;
endtask

task automatic model_response(input logic [hci_pkg::WIDE_DW-1:0] data,
                              input logic [hci_pkg::UW-1:0] user);
  hci_pkg::hci_wide_word_u act_w;
  hci_pkg::hci_wide_word_u exp_w;
  logic                    rd;
  logic [hci_pkg::UW-1:0]  exp_u;
  act_w.word = data;
  rsp_cnt++;
  if (exp_rd.size() == 0) begin
    $display("response seen with no request outstanding"); // duplicate or spurious
    err_cnt++;
  end else begin
    rd    = exp_rd.pop_front();
    exp_w = exp_data.pop_front();
    exp_u = exp_user.pop_front();
    if (rd) check_data(exp_w, act_w);
    check_user(exp_u, user);
  end
endtask

`endif

//--- tests/tb_hci_split_tcdm.sv
// random traffic testbench for the split TCDM port, responses checked against a byte model
`timescale 1ns/1ns
`default_nettype none

module tb_hci_split_tcdm;

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned DRV_DLY      = 10; // inputs change this long after the rising edge
  localparam int unsigned REGION_WORDS = 32; // wide words touched by the tests
  localparam int unsigned N_PARTIAL    = 48;
  localparam int unsigned N_SKEW       = 64;
  localparam int unsigned N_BP         = 64;
  // fill/read, two full read-backs, three random runs
  localparam int unsigned TOTAL_TXN    = 4*REGION_WORDS + N_PARTIAL + N_SKEW + N_BP;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        clear_i;
  logic                        req_i;
  logic                        wen_i;
  logic [hci_pkg::AW-1:0]      add_i;
  logic [hci_pkg::WIDE_BW-1:0] be_i;
  logic [hci_pkg::WIDE_DW-1:0] data_i;
  logic [hci_pkg::UW-1:0]      user_i;
  logic                        r_ready_i;
  logic [hci_pkg::NB_CHAN-1:0] busy_i;
  logic                        gnt_o;
  logic                        r_valid_o;
  logic [hci_pkg::WIDE_DW-1:0] r_data_o;
  logic [hci_pkg::UW-1:0]      r_user_o;

  logic                        busy_mode;  // random bank contention
  logic                        ready_mode; // random back-pressure
  logic [31:0]                 rnd_bg;
  logic [hci_pkg::NB_CHAN-1:0] busy_nxt;
  logic                        ready_nxt;
  int unsigned test_cnt  = 0;
  int unsigned test_fail = 0;
  int unsigned err_at_start;

  `include "tb_hci_split_model.svh"

  hci_split_tcdm_top u_dut (
    .clk_i, .rst_ni, .clear_i, .req_i, .wen_i, .add_i, .be_i, .data_i, .user_i,
    .r_ready_i, .busy_i, .gnt_o, .r_valid_o, .r_data_o, .r_user_o
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  // busy and ready change every cycle, independent of the request driver
  always @(posedge clk_i) begin
    rnd_bg    = $urandom; // next values picked on the edge
    busy_nxt  = busy_mode ? rnd_bg[hci_pkg::NB_CHAN-1:0] : '0;
    ready_nxt = ready_mode ? (rnd_bg[9:8] != 2'b00) : 1'b1;
    #DRV_DLY;
    busy_i    = busy_nxt;
    r_ready_i = ready_nxt;
  end

  // mid-cycle, all outputs settled
  always @(negedge clk_i) begin
    if (rst_ni && r_valid_o && r_ready_i) model_response(r_data_o, r_user_o);
  end

  initial begin
    #(TOTAL_TXN * 40 * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, traffic did not drain", TOTAL_TXN * 40);
    $display("Testbench failed");
    $finish;
  end

  // holds the request until the cycle that takes it
  task automatic send_req(input logic rd, input int unsigned widx,
                          input logic [hci_pkg::WIDE_BW-1:0] be,
                          input logic [hci_pkg::WIDE_DW-1:0] data,
                          input logic [hci_pkg::UW-1:0] user);
    logic taken;
    req_i  = 1'b1;
    wen_i  = rd;
    add_i  = widx * hci_pkg::WIDE_BW;
    be_i   = be;
    data_i = data;
    user_i = user;
    taken  = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = gnt_o; // accepted at the coming edge
    end
    model_accept(rd, widx, be, data, user);
    @(posedge clk_i);
    #DRV_DLY;
    req_i = 1'b0;
  endtask

  task automatic random_ops(input int unsigned n, input logic partial);
    logic [31:0] rnd;
    int unsigned widx;
    for (int k = 0; k < n; k++) begin
      rnd  = $urandom;
      widx = $urandom % REGION_WORDS;
      send_req(rnd[0], widx, partial ? rnd[8 +: hci_pkg::WIDE_BW] : '1,
               {$urandom, $urandom}, rnd[2 +: hci_pkg::UW]);
      if (rnd[31:30] == 2'b00) begin // idle gap now and then
        @(posedge clk_i);
        #DRV_DLY;
      end
    end
  endtask

  task automatic read_all();
    logic [31:0] rnd;
    for (int w = 0; w < REGION_WORDS; w++) begin
      rnd = $urandom;
      send_req(1'b1, w, '1, '0, rnd[hci_pkg::UW-1:0]);
    end
  endtask

  task automatic fill_region();
    logic [31:0] rnd;
    for (int w = 0; w < REGION_WORDS; w++) begin
      rnd = $urandom;
      send_req(1'b0, w, '1, {$urandom, $urandom}, rnd[hci_pkg::UW-1:0]);
    end
  endtask

  task automatic wait_drain();
    @(posedge clk_i);
    while (rsp_cnt < acc_cnt) @(posedge clk_i);
    #DRV_DLY;
  endtask

  task automatic pulse_clear();
    clear_i = 1'b1;
    @(posedge clk_i);
    #DRV_DLY;
    clear_i = 1'b0;
    @(negedge clk_i);
    if (r_valid_o) begin
      $display("r_valid_o still high after clear_i with nothing outstanding");
      err_cnt++;
    end
    @(posedge clk_i);
    #DRV_DLY;
  endtask

  task automatic end_test(input string name);
    int unsigned errs;
    wait_drain();
    check_count("responses", acc_cnt, rsp_cnt);
    check_count("expected queue entries", 0, exp_rd.size());
    pulse_clear(); // between tests, memory must survive it
    errs = err_cnt - err_at_start;
    test_cnt++;
    if (errs == 0) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      test_fail++;
      $display("test %0d %s: %0d errors", test_cnt, name, errs);
    end
    err_at_start = err_cnt;
  endtask

  initial begin
    void'($urandom(32'haac3_1e41));
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    clear_i    = 1'b0;
    req_i      = 1'b0;
    wen_i      = 1'b1;
    add_i      = '0;
    be_i       = '0;
    data_i     = '0;
    user_i     = '0;
    r_ready_i  = 1'b1;
    busy_i     = '0;
    busy_mode  = 1'b0;
    ready_mode = 1'b0;
    err_at_start = 0;
    repeat (4) @(posedge clk_i);
    #DRV_DLY;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #DRV_DLY;

    fill_region(); // every byte defined from here on
    read_all();
    end_test("write then read");
    random_ops(N_PARTIAL, 1'b1);
    end_test("partial byte enables");
    busy_mode = 1'b1;
    random_ops(N_SKEW, 1'b1);
    end_test("lane skew");
    ready_mode = 1'b1;
    random_ops(N_BP, 1'b1);
    end_test("back-pressure");
    busy_mode = 1'b0;
    read_all(); // tags random per request
    end_test("user tags");
    busy_mode = 1'b1;
    read_all(); // data written before the clears
    end_test("clear keeps memory");

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             test_cnt, test_cnt - test_fail, test_fail, err_cnt);
    if (test_fail == 0 && err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hci_split_tcdm_top.f
+incdir+tests
logic/hci_pkg.sv
logic/tcdm_pkg.sv
logic/hci_chan_fifo.sv
logic/tcdm_bank.sv
logic/hci_wide_split.sv
logic/hci_split_tcdm_top.sv
tests/tb_hci_split_tcdm.sv

//--- Bender.yml
package:
  name: hci_split_tcdm

sources:
  # packages first, the RTL files refer to them by scoped names
  - logic/hci_pkg.sv
  - logic/tcdm_pkg.sv
  # RTL
  - logic/hci_chan_fifo.sv
  - logic/tcdm_bank.sv
  - logic/hci_wide_split.sv
  - logic/hci_split_tcdm_top.sv
  # testbench
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_hci_split_tcdm.sv
